// ==== design/core_pkg.sv ====
package core_pkg;

        // primary opcode, instr[31:26]
        typedef enum logic [5:0] {
                op_special = 6'h00,
                op_beq     = 6'h04,
                op_bne     = 6'h05,
                op_addiu   = 6'h09,
                op_ori     = 6'h0d,
                op_lui     = 6'h0f
        } opcode_e;

        // function field under op_special, instr[5:0]
        typedef enum logic [5:0] {
                fn_sll  = 6'h00,
                fn_srl  = 6'h02,
                fn_mfhi = 6'h10,
                fn_mflo = 6'h12,
                fn_mult = 6'h18,
                fn_addu = 6'h21,
                fn_subu = 6'h23,
                fn_and  = 6'h24,
                fn_or   = 6'h25,
                fn_xor  = 6'h26,
                fn_slt  = 6'h2a
        } funct_e;

        typedef enum logic [3:0] {
                alu_add, alu_sub, alu_and, alu_or, alu_xor,
                alu_slt, alu_sll, alu_srl, alu_lui
        } alu_op_e;

        // multiply path: start a mult, or read hi / lo back
        typedef enum logic [1:0] {hl_none, hl_mult, hl_hi, hl_lo} hilo_sel_e;

endpackage

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps
module decode_unit import core_pkg::*; (
        input  logic            Clk,
        input  logic            arst_n,
        input  logic [31:0]     instr,
        input  logic [31:0]     instr_pc,
        input  logic            instr_valid,
        input  logic [31:0]     rd_a,
        input  logic [31:0]     rd_b,
        input  logic            wb_valid,
        input  logic [4:0]      wb_rw,
        input  logic [31:0]     wb_data,
        input  logic            mul_busy,
        input  logic            ex_mult,
        input  logic            redirect,
        output logic [4:0]      ra,
        output logic [4:0]      rb,
        output logic [31:0]     id_bus_a,
        output logic [31:0]     id_bus_b,
        output logic [4:0]      id_ra,
        output logic [4:0]      id_rb,
        output logic [4:0]      id_rw,
        output logic [31:0]     id_imm_ext,
        output logic [4:0]      id_shf,
        output logic            id_reg_wr,
        output logic            id_alu_src,
        output alu_op_e         id_alu_ctr,
        output hilo_sel_e       id_hilo_sel,
        output logic            id_is_beq,
        output logic            id_is_bne,
        output logic [31:0]     id_pc,
        output logic            id_valid,
        output logic            hazard,
        output logic            branch_bubble
);
        opcode_e        opcode;
        funct_e         funct;
        logic           zero_ext;
        logic           mult_q;

        assign opcode = opcode_e'(instr[31:26]);
        assign funct = funct_e'(instr[5:0]);
        assign ra = instr[25:21];
        assign rb = instr[20:16];
        assign id_ra = ra;
        assign id_rb = rb;
        assign id_shf = instr[10:6];
        assign id_pc = instr_pc;
        assign id_valid = instr_valid;

        // R-type writes rd, I-type writes rt
        assign id_rw = (opcode == op_special) ? instr[15:11] : rb;
        assign id_imm_ext = zero_ext ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

        always_comb begin
                id_reg_wr = 1'b0;
                id_alu_src = 1'b0;
                id_alu_ctr = alu_add;
                id_hilo_sel = hl_none;
                id_is_beq = 1'b0;
                id_is_bne = 1'b0;
                zero_ext = 1'b0;
                case (opcode)
                        op_special: begin
                                id_reg_wr = 1'b1;
                                case (funct)
                                        fn_sll:  id_alu_ctr = alu_sll;
                                        fn_srl:  id_alu_ctr = alu_srl;
                                        fn_addu: id_alu_ctr = alu_add;
                                        fn_subu: id_alu_ctr = alu_sub;
                                        fn_and:  id_alu_ctr = alu_and;
                                        fn_or:   id_alu_ctr = alu_or;
                                        fn_xor:  id_alu_ctr = alu_xor;
                                        fn_slt:  id_alu_ctr = alu_slt;
                                        fn_mfhi: id_hilo_sel = hl_hi;
                                        fn_mflo: id_hilo_sel = hl_lo;
                                        fn_mult: begin
                                                id_hilo_sel = hl_mult;
                                                id_reg_wr = 1'b0;
                                        end
                                        // unknown funct is a no-op
                                        default: id_reg_wr = 1'b0;
                                endcase
                        end
                        op_addiu: begin
                                id_reg_wr = 1'b1;
                                id_alu_src = 1'b1;
                        end
                        op_ori: begin
                                id_reg_wr = 1'b1;
                                id_alu_src = 1'b1;
                                id_alu_ctr = alu_or;
                                zero_ext = 1'b1;
                        end
                        op_lui: begin
                                id_reg_wr = 1'b1;
                                id_alu_src = 1'b1;
                                id_alu_ctr = alu_lui;
                                zero_ext = 1'b1;
                        end
                        op_beq: id_is_beq = 1'b1;
                        op_bne: id_is_bne = 1'b1;
                        default: id_reg_wr = 1'b0;
                endcase
        end

        // bypass the value being written back this cycle
        assign id_bus_a = (wb_valid && wb_rw == ra) ? wb_data : rd_a;
        assign id_bus_b = (wb_valid && wb_rw == rb) ? wb_data : rd_b;

        // mult that was in execute one cycle ago
        always_ff @(posedge Clk or negedge arst_n) begin
                if (!arst_n) begin
                        mult_q <= 1'b0;
                end else begin
                        mult_q <= ex_mult;
                end
        end

        // interlock on hi/lo users while a multiply is in flight
        // a squashed slot never stalls
        assign hazard = instr_valid && !redirect && (id_hilo_sel != hl_none) &&
                        (mul_busy || ex_mult || mult_q);
        assign branch_bubble = redirect;

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
module reg_file (
        input  logic            Clk,
        input  logic            arst_n,
        input  logic [4:0]      ra,
        input  logic [4:0]      rb,
        input  logic            we,
        input  logic [4:0]      rw,
        input  logic [31:0]     wd,
        output logic [31:0]     rd_a,
        output logic [31:0]     rd_b
);
        logic [31:0] regs [32];

        always_ff @(posedge Clk or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && rw != 5'd0) begin
                        regs[rw] <= wd;
                end
        end

        // $zero always reads as zero
        assign rd_a = (ra == 5'd0) ? 32'h0 : regs[ra];
        assign rd_b = (rb == 5'd0) ? 32'h0 : regs[rb];

endmodule

// ==== design/id_ex.sv ====
`timescale 1ns/1ps
module id_ex import core_pkg::*; (
        input  logic            Clk,
        input  logic            arst_n,
        input  logic            hazard,
        input  logic            branch_bubble,
        input  logic [31:0]     id_bus_a,
        input  logic [31:0]     id_bus_b,
        input  logic [4:0]      id_ra,
        input  logic [4:0]      id_rb,
        input  logic [4:0]      id_rw,
        input  logic [31:0]     id_imm_ext,
        input  logic [4:0]      id_shf,
        input  logic            id_reg_wr,
        input  logic            id_alu_src,
        input  alu_op_e         id_alu_ctr,
        input  hilo_sel_e       id_hilo_sel,
        input  logic            id_is_beq,
        input  logic            id_is_bne,
        input  logic [31:0]     id_pc,
        input  logic            id_valid,
        output logic [31:0]     ex_bus_a,
        output logic [31:0]     ex_bus_b,
        output logic [4:0]      ex_ra,
        output logic [4:0]      ex_rb,
        output logic [4:0]      ex_rw,
        output logic [31:0]     ex_imm_ext,
        output logic [4:0]      ex_shf,
        output logic            ex_reg_wr,
        output logic            ex_alu_src,
        output alu_op_e         ex_alu_ctr,
        output hilo_sel_e       ex_hilo_sel,
        output logic            ex_is_beq,
        output logic            ex_is_bne,
        output logic [31:0]     ex_pc,
        output logic            ex_valid
);
        logic bubble;

        assign bubble = hazard || branch_bubble;

        // control fields, cleared to a bubble on interlock or squash
        always_ff @(posedge Clk or negedge arst_n) begin
                if (!arst_n) begin
                        ex_reg_wr <= 1'b0;
                        ex_alu_src <= 1'b0;
                        ex_alu_ctr <= alu_add;
                        ex_hilo_sel <= hl_none;
                        ex_is_beq <= 1'b0;
                        ex_is_bne <= 1'b0;
                        ex_valid <= 1'b0;
                end else if (bubble) begin
                        ex_reg_wr <= 1'b0;
                        ex_alu_src <= 1'b0;
                        ex_alu_ctr <= alu_add;
                        ex_hilo_sel <= hl_none;
                        ex_is_beq <= 1'b0;
                        ex_is_bne <= 1'b0;
                        ex_valid <= 1'b0;
                end else begin
                        ex_reg_wr <= id_reg_wr;
                        ex_alu_src <= id_alu_src;
                        ex_alu_ctr <= id_alu_ctr;
                        ex_hilo_sel <= id_hilo_sel;
                        ex_is_beq <= id_is_beq;
                        ex_is_bne <= id_is_bne;
                        ex_valid <= id_valid;
                end
        end

        // data fields hold through a bubble
        always_ff @(posedge Clk) begin
                if (!bubble) begin
                        ex_bus_a <= id_bus_a;
                        ex_bus_b <= id_bus_b;
                        ex_ra <= id_ra;
                        ex_rb <= id_rb;
                        ex_rw <= id_rw;
                        ex_imm_ext <= id_imm_ext;
                        ex_shf <= id_shf;
                        ex_pc <= id_pc;
                end
        end

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps
module execute_unit import core_pkg::*; (
        input  logic [31:0]     ex_bus_a,
        input  logic [31:0]     ex_bus_b,
        input  logic [4:0]      ex_rw,
        input  logic [31:0]     ex_imm_ext,
        input  logic [4:0]      ex_shf,
        input  logic            ex_reg_wr,
        input  logic            ex_alu_src,
        input  alu_op_e         ex_alu_ctr,
        input  hilo_sel_e       ex_hilo_sel,
        input  logic            ex_is_beq,
        input  logic            ex_is_bne,
        input  logic [31:0]     ex_pc,
        input  logic            ex_valid,
        input  logic [31:0]     hi,
        input  logic [31:0]     lo,
        output logic            wb_valid,
        output logic [4:0]      wb_rw,
        output logic [31:0]     wb_data,
        output logic            redirect,
        output logic [31:0]     redirect_pc,
        output logic            mul_start,
        output logic [31:0]     mul_a,
        output logic [31:0]     mul_b
);
        logic [31:0]    op_b;
        logic [31:0]    alu_out;
        logic           equal;

        assign op_b = ex_alu_src ? ex_imm_ext : ex_bus_b;

        always_comb begin
                case (ex_alu_ctr)
                        alu_add: alu_out = ex_bus_a + op_b;
                        alu_sub: alu_out = ex_bus_a - op_b;
                        alu_and: alu_out = ex_bus_a & op_b;
                        alu_or:  alu_out = ex_bus_a | op_b;
                        alu_xor: alu_out = ex_bus_a ^ op_b;
                        alu_slt: alu_out = {31'h0, $signed(ex_bus_a) < $signed(op_b)};
                        // shifts act on rt
                        alu_sll: alu_out = ex_bus_b << ex_shf;
                        alu_srl: alu_out = ex_bus_b >> ex_shf;
                        alu_lui: alu_out = {ex_imm_ext[15:0], 16'h0};
                        default: alu_out = 32'h0;
                endcase
        end

        assign wb_valid = ex_valid && ex_reg_wr && (ex_rw != 5'd0);
        assign wb_rw = ex_rw;
        assign wb_data = (ex_hilo_sel == hl_hi) ? hi :
                         (ex_hilo_sel == hl_lo) ? lo : alu_out;

        // branch target in word units
        assign equal = (ex_bus_a == ex_bus_b);
        assign redirect = ex_valid && ((ex_is_beq && equal) || (ex_is_bne && !equal));
        assign redirect_pc = ex_pc + 32'd1 + ex_imm_ext;

        assign mul_start = ex_valid && (ex_hilo_sel == hl_mult);
        assign mul_a = ex_bus_a;
        assign mul_b = ex_bus_b;

endmodule

// ==== design/mul_unit.sv ====
`timescale 1ns/1ps
module mul_unit #(
        parameter int MUL_CYCLES = 32
) (
        input  logic            Clk,
        input  logic            arst_n,
        input  logic            start,
        input  logic [31:0]     a,
        input  logic [31:0]     b,
        output logic            busy,
        output logic [31:0]     hi,
        output logic [31:0]     lo
);
        // multiplier bits retired per busy cycle
        localparam int STEP = 32 / MUL_CYCLES;
        localparam int CW = $clog2(MUL_CYCLES);

        typedef enum logic {st_idle, st_run} mul_state_e;

        mul_state_e             state;
        logic [CW-1:0]          count;
        logic [31:0]            mcand;
        logic [63:0]            prod;
        logic [31+STEP:0]       upper_sum;
        logic [63:0]            prod_next;

        // upper half accumulates, multiplier shifts out of the low half
        assign upper_sum = {{STEP{1'b0}}, prod[63:32]} + mcand * prod[STEP-1:0];
        assign prod_next = {upper_sum, prod[31:STEP]};
        assign busy = (state == st_run);

        always_ff @(posedge Clk or negedge arst_n) begin
                if (!arst_n) begin
                        state <= st_idle;
                        count <= '0;
                        hi <= '0;
                        lo <= '0;
                end else begin
                        case (state)
                                st_idle: begin
                                        if (start) begin
                                                state <= st_run;
                                                count <= '0;
                                        end
                                end
                                st_run: begin
                                        count <= count + 1'b1;
                                        // last step, product lands as busy falls
                                        if (count == CW'(MUL_CYCLES - 1)) begin
                                                state <= st_idle;
                                                hi <= prod_next[63:32];
                                                lo <= prod_next[31:0];
                                        end
                                end
                        endcase
                end
        end

        always_ff @(posedge Clk) begin
                if (state == st_idle && start) begin
                        mcand <= a;
                        prod <= {32'h0, b};
                end else if (state == st_run) begin
                        prod <= prod_next;
                end
        end

endmodule

// ==== design/pipe_core.sv ====
`timescale 1ns/1ps
module pipe_core import core_pkg::*; #(
        parameter int MUL_CYCLES = 32
) (
        input  logic            Clk,
        input  logic            arst_n,
        input  logic [31:0]     instr,
        input  logic [31:0]     instr_pc,
        input  logic            instr_valid,
        output logic            stall,
        output logic            redirect,
        output logic [31:0]     redirect_pc,
        output logic            wb_valid,
        output logic [4:0]      wb_rw,
        output logic [31:0]     wb_data
);
        // register file read ports
        logic [4:0]     ra;
        logic [4:0]     rb;
        logic [31:0]    rd_a;
        logic [31:0]    rd_b;

        // decode stage fields
        logic [31:0]    id_bus_a;
        logic [31:0]    id_bus_b;
        logic [4:0]     id_ra;
        logic [4:0]     id_rb;
        logic [4:0]     id_rw;
        logic [31:0]    id_imm_ext;
        logic [4:0]     id_shf;
        logic           id_reg_wr;
        logic           id_alu_src;
        alu_op_e        id_alu_ctr;
        hilo_sel_e      id_hilo_sel;
        logic           id_is_beq;
        logic           id_is_bne;
        logic [31:0]    id_pc;
        logic           id_valid;
        logic           hazard;
        logic           branch_bubble;

        // execute stage fields
        logic [31:0]    ex_bus_a;
        logic [31:0]    ex_bus_b;
        logic [4:0]     ex_rw;
        logic [31:0]    ex_imm_ext;
        logic [4:0]     ex_shf;
        logic           ex_reg_wr;
        logic           ex_alu_src;
        alu_op_e        ex_alu_ctr;
        hilo_sel_e      ex_hilo_sel;
        logic           ex_is_beq;
        logic           ex_is_bne;
        logic [31:0]    ex_pc;
        logic           ex_valid;

        // multiplier
        logic           mul_start;
        logic           mul_busy;
        logic [31:0]    mul_a;
        logic [31:0]    mul_b;
        logic [31:0]    hi;
        logic [31:0]    lo;

        assign stall = hazard;

        decode_unit u_decode (
                .*,
                .ex_mult(mul_start)
        );

        reg_file u_regs (
                .*,
                .we(wb_valid),
                .rw(wb_rw),
                .wd(wb_data)
        );

        id_ex u_id_ex (
                .*,
                .ex_ra(),
                .ex_rb()
        );

        execute_unit u_execute (.*);

        mul_unit #(.MUL_CYCLES(MUL_CYCLES)) u_mul (
                .*,
                .start(mul_start),
                .a(mul_a),
                .b(mul_b),
                .busy(mul_busy)
        );

endmodule

// ==== testbench/pipe_core_props.sv ====
`timescale 1ns/1ps
module pipe_core_props (
        input  logic            Clk,
        input  logic            arst_n,
        input  logic            hazard,
        input  logic            branch_bubble,
        input  logic [31:0]     id_pc,
        input  logic            ex_valid,
        input  logic            ex_reg_wr
);
        // a bubble leaves an empty slot in execute
        bubble_clears: assert property (@(posedge Clk) disable iff (!arst_n)
                (hazard || branch_bubble) |=> (!ex_valid && !ex_reg_wr))
                else $error("execute slot not empty after a bubble");

        reset_empty: assert property (@(posedge Clk) $rose(arst_n) |-> !ex_valid)
                else $error("ex_valid set in the first cycle after reset");

        // fetch moves off the squashed PC
        redirect_moves_pc: assert property (@(posedge Clk) disable iff (!arst_n)
                branch_bubble |=> (id_pc != $past(id_pc)))
                else $error("decode PC held across a redirect");
endmodule

bind id_ex pipe_core_props u_props (.*);

// ==== testbench/pipe_core_tb.sv ====
`timescale 1ns/1ps
module pipe_core_tb import core_pkg::*; ();
        localparam int MUL_CYCLES = 32;
        localparam int PROG_WORDS = 64;
        localparam int LAST_PC = PROG_WORDS - 1;
        localparam int CYCLE_LIMIT = PROG_WORDS * (MUL_CYCLES + 3);

        logic           Clk;
        logic           arst_n;
        logic [31:0]    instr;
        logic [31:0]    instr_pc;
        logic           instr_valid;
        logic           stall;
        logic           redirect;
        logic [31:0]    redirect_pc;
        logic           wb_valid;
        logic [4:0]     wb_rw;
        logic [31:0]    wb_data;

        logic [31:0]    prog [PROG_WORDS];
        // expected events in order, {is_branch, reg, value}
        logic [37:0]    expect_q [$];
        logic [31:0]    pc;
        int             n_checks;
        int             n_errors;
        int             cycles;
        int             mult_age;
        bit             done;
        bit             timed_out;

        pipe_core #(.MUL_CYCLES(MUL_CYCLES)) dut0 (.*);

        initial begin
                Clk = 1'b0;
                forever #50 Clk = ~Clk;
        end

        function automatic logic [31:0] r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                               logic [4:0] sh, logic [5:0] fn);
                return {6'h00, rs, rt, rd, sh, fn};
        endfunction

        function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                               logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic bit uses_hilo(logic [31:0] w);
                return w[31:26] == op_special &&
                       (w[5:0] == fn_mult || w[5:0] == fn_mfhi || w[5:0] == fn_mflo);
        endfunction

        function automatic logic [31:0] random_instr(int addr);
                logic [4:0]     rs;
                logic [4:0]     rt;
                logic [4:0]     rd;
                logic [15:0]    imm;
                logic [15:0]    offs;
                logic [31:0]    w;
                int             kind;
                rs = 5'($urandom % 8);
                rt = 5'($urandom % 8);
                rd = 5'($urandom % 8);
                imm = 16'($urandom);
                offs = 16'($urandom % 3 + 1);
                kind = int'($urandom % 16);
                // forward branches must land inside the program
                if (addr > LAST_PC - 4 && (kind == 11 || kind == 12))
                        kind = 8;
                case (kind)
                        0: w = r_type(rs, rt, rd, 5'd0, fn_addu);
                        1: w = r_type(rs, rt, rd, 5'd0, fn_subu);
                        2: w = r_type(rs, rt, rd, 5'd0, fn_and);
                        3: w = r_type(rs, rt, rd, 5'd0, fn_or);
                        4: w = r_type(rs, rt, rd, 5'd0, fn_xor);
                        5: w = r_type(rs, rt, rd, 5'd0, fn_slt);
                        6: w = r_type(5'd0, rt, rd, imm[10:6], fn_sll);
                        7: w = r_type(5'd0, rt, rd, imm[10:6], fn_srl);
                        8: w = i_type(op_addiu, rs, rt, imm);
                        9: w = i_type(op_ori, rs, rt, imm);
                        10: w = i_type(op_lui, 5'd0, rt, imm);
                        11: w = i_type(op_beq, rs, rt, offs);
                        12: w = i_type(op_bne, rs, rt, offs);
                        13: w = r_type(rs, rt, 5'd0, 5'd0, fn_mult);
                        14: w = r_type(5'd0, 5'd0, rd, 5'd0, fn_mfhi);
                        default: w = r_type(5'd0, 5'd0, rd, 5'd0, fn_mflo);
                endcase
                return w;
        endfunction

        // in-order ISA model, fills expect_q
        task automatic run_model();
                logic [31:0]    r [32];
                logic [31:0]    hi;
                logic [31:0]    lo;
                logic [31:0]    w;
                logic [31:0]    a;
                logic [31:0]    b;
                logic [31:0]    se;
                logic [31:0]    res;
                logic [63:0]    prod;
                logic [4:0]     dest;
                bit             wr;
                int             p;
                int             next;
                for (int i = 0; i < 32; i++)
                        r[i] = 32'h0;
                hi = 32'h0;
                lo = 32'h0;
                p = 0;
                while (p < LAST_PC) begin
                        w = prog[p];
                        a = r[w[25:21]];
                        b = r[w[20:16]];
                        se = {{16{w[15]}}, w[15:0]};
                        res = 32'h0;
                        dest = w[20:16];
                        wr = 1'b1;
                        next = p + 1;
                        case (w[31:26])
                                op_special: begin
                                        dest = w[15:11];
                                        case (w[5:0])
                                                fn_addu: res = a + b;
                                                fn_subu: res = a - b;
                                                fn_and:  res = a & b;
                                                fn_or:   res = a | b;
                                                fn_xor:  res = a ^ b;
                                                fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                                                fn_sll:  res = b << w[10:6];
                                                fn_srl:  res = b >> w[10:6];
                                                fn_mfhi: res = hi;
                                                fn_mflo: res = lo;
                                                fn_mult: begin
                                                        prod = {32'h0, a} * {32'h0, b};
                                                        hi = prod[63:32];
                                                        lo = prod[31:0];
                                                        wr = 1'b0;
                                                end
                                                default: wr = 1'b0;
                                        endcase
                                end
                                op_addiu: res = a + se;
                                op_ori: res = a | {16'h0, w[15:0]};
                                op_lui: res = {w[15:0], 16'h0};
                                op_beq, op_bne: begin
                                        wr = 1'b0;
                                        if ((a == b) == (w[31:26] == op_beq)) begin
                                                next = p + 1 + $signed(se);
                                                expect_q.push_back({1'b1, 5'd0, 32'(next)});
                                        end
                                end
                                default: wr = 1'b0;
                        endcase
                        // $zero is never written
                        if (wr && dest != 5'd0) begin
                                r[dest] = res;
                                expect_q.push_back({1'b0, dest, res});
                        end
                        p = next;
                end
        endtask

        task automatic report_error(string msg);
                n_errors++;
                $display("ERROR @ %0t: %s", $time, msg);
        endtask

        task automatic check_outputs();
                logic [37:0]    ev;
                bit             want_stall;
                if (wb_valid) begin
                        n_checks++;
                        if (wb_rw == 5'd0)
                                report_error("write to register 0 reached write-back");
                        if (expect_q.size() == 0) begin
                                report_error($sformatf("unexpected write r%0d = %h", wb_rw, wb_data));
                        end else begin
                                ev = expect_q.pop_front();
                                if (ev[37] || ev[36:32] != wb_rw || ev[31:0] != wb_data)
                                        report_error($sformatf("write r%0d = %h, expected %s r%0d %h",
                                                wb_rw, wb_data, ev[37] ? "redirect" : "write",
                                                ev[36:32], ev[31:0]));
                        end
                end
                if (redirect) begin
                        n_checks++;
                        if (expect_q.size() == 0) begin
                                // only the closing self-branch is left
                                if (redirect_pc == LAST_PC)
                                        done = 1'b1;
                                else
                                        report_error($sformatf("unexpected redirect to %0d",
                                                redirect_pc));
                        end else begin
                                ev = expect_q.pop_front();
                                if (!ev[37] || ev[31:0] != redirect_pc)
                                        report_error($sformatf("redirect to %0d, expected %s %h",
                                                redirect_pc, ev[37] ? "redirect" : "write",
                                                ev[31:0]));
                        end
                end
                // interlock from mult acceptance until busy has fallen
                want_stall = instr_valid && !redirect && uses_hilo(instr) &&
                             mult_age <= MUL_CYCLES;
                n_checks++;
                if (stall != want_stall)
                        report_error($sformatf("stall %0b at pc %0d, expected %0b",
                                stall, instr_pc, want_stall));
        endtask

        task automatic advance_fetch();
                if (instr_valid && !stall && !redirect && uses_hilo(instr) &&
                    instr[5:0] == fn_mult)
                        mult_age = 0;
                else if (mult_age < CYCLE_LIMIT)
                        mult_age++;
                if (redirect)
                        pc = redirect_pc;
                else if (!stall)
                        pc = pc + 32'd1;
                instr <= (pc < PROG_WORDS) ? prog[pc[5:0]] : 32'h0;
                instr_pc <= pc;
        endtask

        initial begin
                arst_n = 1'b0;
                instr = 32'h0;
                instr_pc = 32'h0;
                instr_valid = 1'b0;
                n_checks = 0;
                n_errors = 0;
                cycles = 0;
                mult_age = CYCLE_LIMIT;
                done = 1'b0;
                timed_out = 1'b0;
                pc = 32'h0;
                void'($urandom(13));
                for (int i = 0; i < LAST_PC; i++)
                        prog[i] = random_instr(i);
                // beq $0, $0, -1 parks fetch at the end
                prog[LAST_PC] = i_type(op_beq, 5'd0, 5'd0, 16'hffff);
                run_model();

                repeat (2) @(posedge Clk);
                arst_n <= 1'b1;
                repeat (3) begin
                        @(posedge Clk);
                        n_checks++;
                        if (wb_valid || redirect || stall)
                                report_error("output active before the first instruction");
                end
                instr <= prog[0];
                instr_pc <= 32'h0;
                instr_valid <= 1'b1;

                while (!done && !timed_out) begin
                        @(posedge Clk);
                        check_outputs();
                        advance_fetch();
                        cycles++;
                        if (cycles >= CYCLE_LIMIT)
                                timed_out = 1'b1;
                end
                if (timed_out && !done)
                        $display("program did not finish within %0d cycles", CYCLE_LIMIT);

                $display("%0d checks, %0d errors, %0d cycles", n_checks, n_errors, cycles);
                if (n_errors == 0 && done) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

endmodule

// ==== pipe_core.f ====
design/core_pkg.sv
design/decode_unit.sv
design/reg_file.sv
design/id_ex.sv
design/execute_unit.sv
design/mul_unit.sv
design/pipe_core.sv
testbench/pipe_core_props.sv
testbench/pipe_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the failure line in the log
verilator --binary --timing --assert -Wno-fatal --top-module pipe_core_tb \
        -f pipe_core.f -o pipe_core_sim > build.log 2>&1 &&
        ./obj_dir/pipe_core_sim > sim.log 2>&1 ||
        { cat build.log sim.log; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
